//--- hw/ctl_regs.sv
// control registers
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module ctl_regs (
	input logic clk,
	input logic rst_n,
	input logic [`PGEN_FLIT_W-1:0] cin_data,
	input logic cin_wr,
	output logic [`PGEN_FLIT_W-1:0] cout_data,
	output logic cout_wr,
	output logic start,
	output logic [31:0] gap,
	output logic [31:0] limit,
	input logic [63:0] sent_pkts,
	input logic [63:0] sent_bytes
);

	pgen_ctl_pkg::ctl_op_e op;
	pgen_ctl_pkg::reg_idx_e idx;
	logic is_head;
	logic is_tail;
	logic local_hit;
	logic local_wr;
	logic local_rd;
	logic wr_pending;
	logic [`PGEN_DATA_W-1:0] rd_val;
	logic [`PGEN_FLIT_W-1:0] reply;

	// ********************
	// head decode
	// ********************
	assign op = pgen_ctl_pkg::ctl_op_e'(cin_data[`PGEN_OP_HI:`PGEN_OP_LO]);
	assign is_head = cin_wr && (cin_data[`PGEN_TAG_HI:`PGEN_TAG_LO] == pgen_pkt_pkg::TAG_HEAD);
	assign is_tail = cin_wr && (cin_data[`PGEN_TAG_HI:`PGEN_TAG_LO] == pgen_pkt_pkg::TAG_TAIL);
	assign local_hit = is_head && (cin_data[`PGEN_DST_HI:`PGEN_DST_LO] == `PGEN_LOCAL_MID);
	assign local_wr = local_hit && (op == pgen_ctl_pkg::OP_WRITE);
	assign local_rd = local_hit && (op == pgen_ctl_pkg::OP_READ);

	always_comb begin
		case (cin_data[`PGEN_ADDR_HI:`PGEN_ADDR_LO])
			`PGEN_REG_START: idx = pgen_ctl_pkg::REG_START;
			`PGEN_REG_GAP: idx = pgen_ctl_pkg::REG_GAP;
			`PGEN_REG_LIMIT: idx = pgen_ctl_pkg::REG_LIMIT;
			`PGEN_REG_SENT_PKTS: idx = pgen_ctl_pkg::REG_SENT_PKTS;
			`PGEN_REG_SENT_BYTES_LO: idx = pgen_ctl_pkg::REG_BYTES_LO;
			`PGEN_REG_SENT_BYTES_HI: idx = pgen_ctl_pkg::REG_BYTES_HI;
			default: idx = pgen_ctl_pkg::REG_NONE;
		endcase
	end

	// start is a strobe and reads as zero
	always_comb begin
		case (idx)
			pgen_ctl_pkg::REG_START: rd_val = '0;
			pgen_ctl_pkg::REG_GAP: rd_val = gap;
			pgen_ctl_pkg::REG_LIMIT: rd_val = limit;
			pgen_ctl_pkg::REG_SENT_PKTS: rd_val = sent_pkts[31:0];
			pgen_ctl_pkg::REG_BYTES_LO: rd_val = sent_bytes[31:0];
			pgen_ctl_pkg::REG_BYTES_HI: rd_val = sent_bytes[63:32];
			default: rd_val = '1;
		endcase
	end

	// reply head with swapped ids and the value in the low word
	always_comb begin
		reply = cin_data;
		reply[`PGEN_OP_HI:`PGEN_OP_LO] = pgen_ctl_pkg::OP_REPLY;
		reply[`PGEN_SRC_HI:`PGEN_SRC_LO] = cin_data[`PGEN_DST_HI:`PGEN_DST_LO];
		reply[`PGEN_DST_HI:`PGEN_DST_LO] = cin_data[`PGEN_SRC_HI:`PGEN_SRC_LO];
		reply[`PGEN_DATA_W-1:0] = rd_val;
	end

	// ********************
	// register writes and output
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cout_wr <= 1'b0;
			start <= 1'b0;
			gap <= `PGEN_GAP_DEFAULT;
			limit <= '0;
			wr_pending <= 1'b0;
		end else begin
			start <= 1'b0;
			cout_wr <= cin_wr;
			if (local_wr) begin
				// head and tail of a local write are both consumed
				cout_wr <= 1'b0;
				wr_pending <= 1'b1;
				case (idx)
					pgen_ctl_pkg::REG_START: start <= 1'b1;
					pgen_ctl_pkg::REG_GAP: gap <= cin_data[`PGEN_DATA_W-1:0];
					pgen_ctl_pkg::REG_LIMIT: limit <= cin_data[`PGEN_DATA_W-1:0];
					default: ;
				endcase
			end else if (wr_pending && cin_wr) begin
				cout_wr <= 1'b0;
				if (is_tail) begin
					wr_pending <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		cout_data <= local_rd ? reply : cin_data;
	end

endmodule

//--- hw/out_arbiter.sv
// output arbiter
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module out_arbiter (
	input logic clk,
	input logic rst_n,
	pkt_src_if.arb usr,
	pkt_src_if.arb gen,
	output logic [`PGEN_FLIT_W-1:0] out_data,
	output logic out_wr
);

	logic usr_gnt;
	logic gen_gnt;

	// ********************
	// packet-granular grant
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			usr_gnt <= 1'b0;
			gen_gnt <= 1'b0;
		end else if (usr_gnt || gen_gnt) begin
			// hold until the granted tail goes out
			if (usr_gnt && usr.wr && usr.last) begin
				usr_gnt <= 1'b0;
			end
			if (gen_gnt && gen.wr && gen.last) begin
				gen_gnt <= 1'b0;
			end
		end else if (usr.req) begin
			usr_gnt <= 1'b1;
		end else if (gen.req) begin
			gen_gnt <= 1'b1;
		end
	end

	assign usr.grant = usr_gnt;
	assign gen.grant = gen_gnt;

	// output register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_wr <= 1'b0;
		end else begin
			out_wr <= (usr_gnt && usr.wr) || (gen_gnt && gen.wr);
		end
	end

	always_ff @(posedge clk) begin
		out_data <= usr_gnt ? usr.flit : gen.flit;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(usr.grant && gen.grant));

endmodule

//--- hw/pgen_ctl_pkg.sv
// control packet types
package pgen_ctl_pkg;

	// control opcodes
	typedef enum logic [2:0] {
		OP_NONE = 3'b000,
		OP_READ = 3'b001,
		OP_WRITE = 3'b010,
		OP_REPLY = 3'b011
	} ctl_op_e;

	// decoded register index
	typedef enum logic [2:0] {
		REG_START,
		REG_GAP,
		REG_LIMIT,
		REG_SENT_PKTS,
		REG_BYTES_LO,
		REG_BYTES_HI,
		REG_NONE
	} reg_idx_e;

endpackage

//--- hw/pgen_pkt_pkg.sv
// flit format types
`include "pgen_cfg.svh"

package pgen_pkt_pkg;

	// flit framing tag
	typedef enum logic [1:0] {
		TAG_NONE = 2'b00,
		TAG_HEAD = 2'b01,
		TAG_TAIL = 2'b10,
		TAG_BODY = 2'b11
	} flit_tag_e;

	// one data flit
	typedef struct packed {
		flit_tag_e tag;
		// valid bytes of a tail, 0 stands for a full 16
		logic [3:0] nbytes;
		logic [`PGEN_FLIT_W-7:0] payload;
	} flit_t;

endpackage

//--- hw/pkt_gen_top.sv
// packet generator top
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module pkt_gen_top (
	input logic clk,
	input logic rst_n,
	input logic [`PGEN_FLIT_W-1:0] in_data,
	input logic in_wr,
	output logic [`PGEN_FLIT_W-1:0] out_data,
	output logic out_wr,
	input logic [`PGEN_FLIT_W-1:0] cin_data,
	input logic cin_wr,
	output logic [`PGEN_FLIT_W-1:0] cout_data,
	output logic cout_wr,
	input logic tmpl_wr,
	input logic [`PGEN_TMPL_AW-1:0] tmpl_addr,
	input logic [`PGEN_FLIT_W-1:0] tmpl_data
);

	logic start;
	logic [31:0] gap;
	logic [31:0] limit;
	logic [63:0] sent_pkts;
	logic [63:0] sent_bytes;

	// one link per packet source
	pkt_src_if usr_if ();
	pkt_src_if gen_if ();

	ctl_regs u_ctl (
		.clk(clk),
		.rst_n(rst_n),
		.cin_data(cin_data),
		.cin_wr(cin_wr),
		.cout_data(cout_data),
		.cout_wr(cout_wr),
		.start(start),
		.gap(gap),
		.limit(limit),
		.sent_pkts(sent_pkts),
		.sent_bytes(sent_bytes)
	);

	tmpl_player u_player (
		.clk(clk),
		.rst_n(rst_n),
		.tmpl_wr(tmpl_wr),
		.tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data),
		.start(start),
		.gap(gap),
		.limit(limit),
		.sent_pkts(sent_pkts),
		.sent_bytes(sent_bytes),
		.src(gen_if)
	);

	user_pkt_queue u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_wr(in_wr),
		.src(usr_if)
	);

	out_arbiter u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.usr(usr_if),
		.gen(gen_if),
		.out_data(out_data),
		.out_wr(out_wr)
	);

endmodule

//--- hw/pkt_src_if.sv
// packet source link
`timescale 1ns/1ps

interface pkt_src_if;

	// whole packet ready at the source
	logic req;
	// held by the arbiter until the tail
	logic grant;
	pgen_pkt_pkg::flit_t flit;
	logic wr;
	logic last;

	modport src (
		output req,
		output flit,
		output wr,
		output last,
		input grant
	);

	modport arb (
		input req,
		input flit,
		input wr,
		input last,
		output grant
	);

endinterface

//--- hw/tmpl_player.sv
// template packet player
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module tmpl_player (
	input logic clk,
	input logic rst_n,
	input logic tmpl_wr,
	input logic [`PGEN_TMPL_AW-1:0] tmpl_addr,
	input logic [`PGEN_FLIT_W-1:0] tmpl_data,
	input logic start,
	input logic [31:0] gap,
	input logic [31:0] limit,
	output logic [63:0] sent_pkts,
	output logic [63:0] sent_bytes,
	pkt_src_if.src src
);

	typedef enum logic [2:0] {IDLE, FETCH, SEND, GAP, DONE} state_e;

	logic [`PGEN_FLIT_W-1:0] mem [0:(1 << `PGEN_TMPL_AW)-1];
	state_e state;
	// extra top bit flags a read past the last word
	logic [`PGEN_TMPL_AW:0] rd_addr;
	pgen_pkt_pkg::flit_t rd_q;
	logic rd_vld;
	logic tail_out;
	logic [4:0] flit_bytes;
	logic [31:0] gap_cnt;
	logic [63:0] pkts_next;

	// ********************
	// template memory
	// ********************
	always_ff @(posedge clk) begin
		if (tmpl_wr) begin
			mem[tmpl_addr] <= tmpl_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_q <= mem[rd_addr[`PGEN_TMPL_AW-1:0]];
	end

	assign tail_out = rd_vld && (rd_q.tag == pgen_pkt_pkg::TAG_TAIL);
	assign flit_bytes = (tail_out && rd_q.nbytes != 4'd0) ? {1'b0, rd_q.nbytes} : 5'd16;
	assign pkts_next = sent_pkts + 64'd1;

	// ********************
	// replay FSM
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			rd_addr <= '0;
			rd_vld <= 1'b0;
			gap_cnt <= '0;
			sent_pkts <= '0;
			sent_bytes <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					// start is ignored while a run is going
					if (start) begin
						sent_pkts <= '0;
						sent_bytes <= '0;
						state <= (limit == 32'd0) ? DONE : FETCH;
					end
				end
				FETCH: begin
					if (src.grant) begin
						rd_addr <= '0;
						state <= SEND;
					end
				end
				SEND: begin
					rd_addr <= rd_addr + 1'b1;
					rd_vld <= !tail_out;
					if (rd_vld) begin
						sent_bytes <= sent_bytes + {59'd0, flit_bytes};
					end
					if (tail_out) begin
						sent_pkts <= pkts_next;
						gap_cnt <= '0;
						state <= (pkts_next >= {32'd0, limit}) ? DONE : GAP;
					end
				end
				GAP: begin
					if (gap_cnt + 32'd1 >= gap) begin
						state <= FETCH;
					end else begin
						gap_cnt <= gap_cnt + 32'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// req stays up through the copy and falls with the tail
	assign src.req = (state == FETCH) || (state == SEND && !tail_out);
	assign src.flit = rd_q;
	assign src.wr = rd_vld;
	assign src.last = tail_out;

	// a template with no tail in memory would wrap the read pointer
	a_rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state == SEND && !tail_out) |-> !rd_addr[`PGEN_TMPL_AW]);

endmodule

//--- hw/user_pkt_queue.sv
// user packet queue
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module user_pkt_queue (
	input logic clk,
	input logic rst_n,
	input logic [`PGEN_FLIT_W-1:0] in_data,
	input logic in_wr,
	pkt_src_if.src src
);

	logic [`PGEN_FLIT_W-1:0] mem [0:(1 << `PGEN_FIFO_AW)-1];
	pgen_pkt_pkg::flit_t in_flit;
	pgen_pkt_pkg::flit_t head_flit;
	pgen_pkt_pkg::flit_t rd_q;
	logic [`PGEN_FIFO_AW:0] wr_ptr;
	logic [`PGEN_FIFO_AW:0] rd_ptr;
	logic [`PGEN_FIFO_AW:0] pkt_cnt;
	logic in_pkt;
	logic fifo_wr;
	logic fifo_rd;
	logic full;
	logic tail_in;
	logic tail_rd;
	logic stop;
	logic rd_vld;

	assign in_flit = in_data;
	assign head_flit = mem[rd_ptr[`PGEN_FIFO_AW-1:0]];

	// ********************
	// framing filter
	// ********************
	// body and tail only pass inside a packet
	always_comb begin
		case (in_flit.tag)
			pgen_pkt_pkg::TAG_HEAD: fifo_wr = in_wr;
			pgen_pkt_pkg::TAG_BODY, pgen_pkt_pkg::TAG_TAIL: fifo_wr = in_wr && in_pkt;
			default: fifo_wr = 1'b0;
		endcase
	end

	assign tail_in = fifo_wr && (in_flit.tag == pgen_pkt_pkg::TAG_TAIL);
	assign full = (wr_ptr[`PGEN_FIFO_AW] != rd_ptr[`PGEN_FIFO_AW]) &&
		(wr_ptr[`PGEN_FIFO_AW-1:0] == rd_ptr[`PGEN_FIFO_AW-1:0]);

	// read until the tail has been taken
	assign fifo_rd = src.grant && !stop;
	assign tail_rd = fifo_rd && (head_flit.tag == pgen_pkt_pkg::TAG_TAIL);

	always_ff @(posedge clk) begin
		if (fifo_wr) begin
			mem[wr_ptr[`PGEN_FIFO_AW-1:0]] <= in_data;
		end
		if (fifo_rd) begin
			rd_q <= head_flit;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_pkt <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			pkt_cnt <= '0;
			stop <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			if (fifo_wr && in_flit.tag == pgen_pkt_pkg::TAG_HEAD) begin
				in_pkt <= 1'b1;
			end else if (tail_in) begin
				in_pkt <= 1'b0;
			end
			if (fifo_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (fifo_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// complete packets held
			case ({tail_in, tail_rd})
				2'b10: pkt_cnt <= pkt_cnt + 1'b1;
				2'b01: pkt_cnt <= pkt_cnt - 1'b1;
				default: pkt_cnt <= pkt_cnt;
			endcase
			if (!src.grant) begin
				stop <= 1'b0;
			end else if (tail_rd) begin
				stop <= 1'b1;
			end
			rd_vld <= fifo_rd;
		end
	end

	assign src.req = (pkt_cnt != '0) && !(stop && src.grant);
	assign src.flit = rd_q;
	assign src.wr = rd_vld;
	assign src.last = rd_vld && (rd_q.tag == pgen_pkt_pkg::TAG_TAIL);

	// no back-pressure upstream, so the sender must never overrun the queue
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_wr |-> !full);

endmodule

//--- include/pgen_cfg.svh
// packet generator configuration
`ifndef PGEN_CFG_SVH
`define PGEN_CFG_SVH

// flit layout, tag in the top two bits
`define PGEN_FLIT_W 134
`define PGEN_TAG_HI 133
`define PGEN_TAG_LO 132

// control flit fields
`define PGEN_OP_HI 126
`define PGEN_OP_LO 124
`define PGEN_SRC_HI 111
`define PGEN_SRC_LO 104
`define PGEN_DST_HI 103
`define PGEN_DST_LO 96
`define PGEN_ADDR_HI 95
`define PGEN_ADDR_LO 64
`define PGEN_DATA_W 32

`define PGEN_LOCAL_MID 8'd62

// storage sizes
`define PGEN_TMPL_AW 7
`define PGEN_FIFO_AW 4

// register map
`define PGEN_REG_START 32'h0000_0000
`define PGEN_REG_GAP 32'h0001_0001
`define PGEN_REG_LIMIT 32'h0001_0002
`define PGEN_REG_SENT_PKTS 32'h0000_0005
`define PGEN_REG_SENT_BYTES_LO 32'h0000_0003
`define PGEN_REG_SENT_BYTES_HI 32'h0000_0004

`define PGEN_GAP_DEFAULT 32'd8

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the packet generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pkt_gen -f src.f --Mdir obj_dir -o tb_pkt_gen
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_pkt_gen > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src.f
+incdir+include
hw/pgen_pkt_pkg.sv
hw/pgen_ctl_pkg.sv
hw/pkt_src_if.sv
hw/tmpl_player.sv
hw/user_pkt_queue.sv
hw/out_arbiter.sv
hw/ctl_regs.sv
hw/pkt_gen_top.sv
verif/tb_pkt_gen.sv

//--- verif/tb_pkt_gen.sv
// packet generator testbench
`timescale 1ns/1ps
`include "pgen_cfg.svh"

module tb_pkt_gen;

	localparam int W = `PGEN_FLIT_W;
	localparam int MAX_K = 5;
	localparam int MAX_GAP = 9;
	localparam int MAX_TLEN = 8;
	localparam int USR_PKTS = 6;
	localparam int MAX_PLEN = 5;
	localparam int MAX_IDLE = 30;
	localparam int SETUP_CYCLES = 80;
	localparam int RUN_CYCLES = MAX_K * (MAX_TLEN + MAX_GAP + 6) +
		USR_PKTS * (MAX_PLEN + 3 + MAX_IDLE) + 60;
	localparam int CYCLE_LIMIT = SETUP_CYCLES + RUN_CYCLES + 200;
	// payload markers tell the output streams apart
	localparam logic [15:0] MK_TMPL = 16'h7e7e;
	localparam logic [15:0] MK_USR = 16'h5a5a;
	localparam logic [15:0] MK_STRAY = 16'hdead;

	logic clk = 1'b0;
	logic rst_n;
	logic [W-1:0] in_data;
	logic in_wr;
	logic [W-1:0] out_data;
	logic out_wr;
	logic [W-1:0] cin_data;
	logic cin_wr;
	logic [W-1:0] cout_data;
	logic cout_wr;
	logic tmpl_wr;
	logic [`PGEN_TMPL_AW-1:0] tmpl_addr;
	logic [W-1:0] tmpl_data;

	integer seed;
	int cyc = 0;
	int cur_test = 0;
	int errors [6] = '{0, 0, 0, 0, 0, 0};
	string names [6] = '{"reg_access", "pass_through", "template_replay",
		"user_priority", "framing_filter", "statistics"};
	logic [W-1:0] tmpl [MAX_TLEN];
	int tlen = 0;
	int k_lim = 0;
	int gap_val = 0;
	logic [63:0] tmpl_bytes;
	logic [63:0] exp_bytes;
	logic [W-1:0] cq_data [$];
	int cq_cyc [$];
	logic [W-1:0] uq [$];
	int copies = 0;
	int tidx = 0;
	int last_tail = 0;
	bit in_tmpl = 1'b0;
	bit in_usr = 1'b0;
	int total_errors;
	int failed_tests;

	pkt_gen_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_wr(in_wr),
		.out_data(out_data),
		.out_wr(out_wr),
		.cin_data(cin_data),
		.cin_wr(cin_wr),
		.cout_data(cout_data),
		.cout_wr(cout_wr),
		.tmpl_wr(tmpl_wr),
		.tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data)
	);

	always #5 clk = ~clk;

	// cycle count and run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_value(input int t, input string what, input logic [W-1:0] exp,
		input logic [W-1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[t], what, exp, act);
			errors[t]++;
		end
	endtask

	task automatic report(input int t, input string msg);
		$display("%s: %s", names[t], msg);
		errors[t]++;
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [W-1:0] make_flit(input logic [1:0] tag, input logic [3:0] nb,
		input logic [15:0] mark);
		logic [159:0] r;
		logic [W-1:0] f;
		r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		f = r[W-1:0];
		f[133:132] = tag;
		f[131:128] = nb;
		f[127:112] = mark;
		return f;
	endfunction

	function automatic logic [W-1:0] make_ctl(input logic [2:0] op, input logic [7:0] dst,
		input logic [31:0] addr, input logic [31:0] data);
		logic [W-1:0] f;
		f = make_flit(pgen_pkt_pkg::TAG_HEAD, 4'd0, 16'h0);
		f[`PGEN_OP_HI:`PGEN_OP_LO] = op;
		f[`PGEN_DST_HI:`PGEN_DST_LO] = dst;
		f[`PGEN_SRC_HI:`PGEN_SRC_LO] = 8'($random(seed));
		f[`PGEN_ADDR_HI:`PGEN_ADDR_LO] = addr;
		f[`PGEN_DATA_W-1:0] = data;
		return f;
	endfunction

	// ********************
	// control port
	// ********************
	// two-flit packet, each expected output due one cycle after its input
	task automatic send_ctl(input logic [W-1:0] head, input logic [W-1:0] exp_head,
		input bit head_out, input bit tail_out);
		logic [W-1:0] tail;
		tail = make_flit(pgen_pkt_pkg::TAG_TAIL, 4'd0, 16'h0);
		cin_data = head;
		cin_wr = 1'b1;
		if (head_out) begin
			cq_data.push_back(exp_head);
			cq_cyc.push_back(cyc + 1);
		end
		tick();
		cin_data = tail;
		if (tail_out) begin
			cq_data.push_back(tail);
			cq_cyc.push_back(cyc + 1);
		end
		tick();
		cin_wr = 1'b0;
	endtask

	task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
		send_ctl(make_ctl(pgen_ctl_pkg::OP_WRITE, `PGEN_LOCAL_MID, addr, data), '0, 1'b0, 1'b0);
	endtask

	task automatic reg_read(input logic [31:0] addr, input logic [31:0] val);
		logic [W-1:0] head;
		logic [W-1:0] exp;
		head = make_ctl(pgen_ctl_pkg::OP_READ, `PGEN_LOCAL_MID, addr, $random(seed));
		exp = head;
		exp[`PGEN_OP_HI:`PGEN_OP_LO] = pgen_ctl_pkg::OP_REPLY;
		exp[`PGEN_SRC_HI:`PGEN_SRC_LO] = head[`PGEN_DST_HI:`PGEN_DST_LO];
		exp[`PGEN_DST_HI:`PGEN_DST_LO] = head[`PGEN_SRC_HI:`PGEN_SRC_LO];
		exp[`PGEN_DATA_W-1:0] = val;
		send_ctl(head, exp, 1'b1, 1'b1);
	endtask

	task automatic send_foreign();
		logic [7:0] dst;
		logic [W-1:0] head;
		dst = 8'($random(seed));
		if (dst == `PGEN_LOCAL_MID) begin
			dst = dst + 8'd1;
		end
		head = make_ctl(3'($random(seed)), dst, $random(seed), $random(seed));
		send_ctl(head, head, 1'b1, 1'b1);
	endtask

	// ********************
	// data side stimulus
	// ********************
	task automatic load_template();
		logic [1:0] tag;
		tlen = 2 + {$random(seed)} % (MAX_TLEN - 1);
		tmpl_bytes = '0;
		tmpl_addr = '0;
		for (int i = 0; i < tlen; i++) begin
			tag = (i == 0) ? pgen_pkt_pkg::TAG_HEAD :
				(i == tlen - 1) ? pgen_pkt_pkg::TAG_TAIL : pgen_pkt_pkg::TAG_BODY;
			tmpl[i] = make_flit(tag, 4'($random(seed)), MK_TMPL);
			// tail counts its nbytes, 0 meaning a full flit
			if (i == tlen - 1 && tmpl[i][131:128] != 4'd0) begin
				tmpl_bytes = tmpl_bytes + 64'(tmpl[i][131:128]);
			end else begin
				tmpl_bytes = tmpl_bytes + 64'd16;
			end
			tmpl_data = tmpl[i];
			tmpl_wr = 1'b1;
			tick();
			tmpl_addr = tmpl_addr + 1'b1;
		end
		tmpl_wr = 1'b0;
	endtask

	task automatic send_user_pkt(input int nbody);
		logic [W-1:0] f;
		for (int i = 0; i <= nbody + 1; i++) begin
			if (i == 0) begin
				f = make_flit(pgen_pkt_pkg::TAG_HEAD, 4'd0, MK_USR);
			end else if (i == nbody + 1) begin
				f = make_flit(pgen_pkt_pkg::TAG_TAIL, 4'($random(seed)), MK_USR);
			end else begin
				f = make_flit(pgen_pkt_pkg::TAG_BODY, 4'd0, MK_USR);
			end
			uq.push_back(f);
			in_data = f;
			in_wr = 1'b1;
			tick();
		end
		in_wr = 1'b0;
	endtask

	// body and tail flits outside any packet
	task automatic send_strays(input int n);
		for (int i = 0; i < n; i++) begin
			in_data = make_flit(($random(seed) & 1) ? pgen_pkt_pkg::TAG_BODY :
				pgen_pkt_pkg::TAG_TAIL, 4'd0, MK_STRAY);
			in_wr = 1'b1;
			tick();
		end
		in_wr = 1'b0;
	endtask

	task automatic finish_test(input int t);
		repeat (3) tick();
		if (cq_data.size() != 0) begin
			report(t, "an expected control output never appeared");
			cq_data.delete();
			cq_cyc.delete();
		end
		$display("%s done, %0d errors", names[t], errors[t]);
	endtask

	// ********************
	// output monitors
	// ********************
	always @(negedge clk) begin
		if (rst_n && cout_wr) begin
			if (cq_data.size() == 0) begin
				report(cur_test, "a control flit came out with none expected");
			end else begin
				check_value(cur_test, "cout_data", cq_data.pop_front(), cout_data);
				check_value(cur_test, "cout cycle", W'(cq_cyc.pop_front()), W'(cyc));
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && out_wr) begin
			if (out_data[127:112] == MK_STRAY) begin
				report(4, "a stray flit reached the data output");
			end else begin
				// a head decides which stream the packet belongs to
				if (!in_tmpl && !in_usr) begin
					if (out_data[127:112] == MK_TMPL) begin
						if (copies >= k_lim) begin
							report(2, "a template copy was sent past the limit");
						end
						if (copies > 0 && cyc - last_tail - 1 < gap_val) begin
							report(2, "the idle time after a copy was shorter than the gap");
						end
						in_tmpl = 1'b1;
						tidx = 0;
					end else begin
						in_usr = 1'b1;
					end
				end
				if (in_tmpl && tidx >= tlen) begin
					report(2, "a template copy ran longer than the template");
				end else if (in_tmpl) begin
					check_value(2, "template flit", tmpl[tidx], out_data);
					tidx++;
				end else if (uq.size() == 0) begin
					report(3, "a user flit came out with no packet queued");
				end else begin
					check_value(3, "user flit", uq.pop_front(), out_data);
				end
				if (out_data[133:132] == pgen_pkt_pkg::TAG_TAIL) begin
					if (in_tmpl) begin
						copies++;
						last_tail = cyc;
					end
					in_tmpl = 1'b0;
					in_usr = 1'b0;
				end
			end
		end
	end

	initial begin
		seed = 32'h2f6c_96a5;
		rst_n = 1'b0;
		in_data = '0;
		in_wr = 1'b0;
		cin_data = '0;
		cin_wr = 1'b0;
		tmpl_wr = 1'b0;
		tmpl_addr = '0;
		tmpl_data = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tick();

		gap_val = 2 + {$random(seed)} % (MAX_GAP - 1);
		k_lim = 2 + {$random(seed)} % (MAX_K - 1);
		reg_write(`PGEN_REG_GAP, gap_val);
		reg_write(`PGEN_REG_LIMIT, k_lim);
		reg_read(`PGEN_REG_GAP, gap_val);
		reg_read(`PGEN_REG_LIMIT, k_lim);
		reg_read(32'h0000_0777, 32'hffff_ffff);
		finish_test(0);

		cur_test = 1;
		for (int i = 0; i < 4; i++) begin
			send_foreign();
			reg_write(`PGEN_REG_GAP, gap_val);
		end
		finish_test(1);

		// user traffic and strays run alongside the replay
		cur_test = 2;
		load_template();
		reg_write(`PGEN_REG_START, 32'd0);
		for (int p = 0; p < USR_PKTS; p++) begin
			send_user_pkt({$random(seed)} % (MAX_PLEN - 1));
			send_strays(1 + {$random(seed)} % 3);
			repeat (16 + {$random(seed)} % (MAX_IDLE - 15)) tick();
		end
		while (copies < k_lim || uq.size() != 0 || in_usr) begin
			tick();
		end
		repeat (60) tick();
		check_value(2, "template copies", W'(k_lim), W'(copies));
		finish_test(2);
		finish_test(3);
		finish_test(4);

		cur_test = 5;
		exp_bytes = tmpl_bytes * 64'(k_lim);
		reg_read(`PGEN_REG_SENT_PKTS, k_lim);
		reg_read(`PGEN_REG_SENT_BYTES_LO, exp_bytes[31:0]);
		reg_read(`PGEN_REG_SENT_BYTES_HI, exp_bytes[63:32]);
		finish_test(5);

		total_errors = 0;
		failed_tests = 0;
		for (int t = 0; t < 6; t++) begin
			total_errors += errors[t];
			failed_tests += (errors[t] != 0) ? 1 : 0;
		end
		$display("tests 6, failed %0d, errors %0d", failed_tests, total_errors);
		if (total_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
